// File: Makefile
# Verilator flow for the sprite line renderer

TOP := sprite_render_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f sources.f --top-module $(TOP)

obj_dir/V$(TOP): sources.f source/*.sv tests/*.sv
	verilator --binary --timing --assert -f sources.f --top-module $(TOP)

# nonzero exit from the binary on any failing run
sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// File: source/sprite_blitter.sv
/*
 * sprite blitter
 * queues pattern rows and shifts each one out as eight pixel
 * writes, dropping transparent and off-line pixels
 */
`timescale 1ns/10ps

module sprite_blitter import sprite_pkg::*; (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       row_valid,
    input  pattern_row_t               row,
    output logic                       credit_return,
    output logic                       wr_en,
    output logic [line_addr_width-1:0] wr_x,
    output pixel_t                     wr_pixel,
    output logic                       idle
);

    localparam int ptr_width   = $clog2(row_queue_depth);
    localparam int count_width = $clog2(row_queue_depth + 1);

    pattern_row_t           queue [row_queue_depth];
    logic [ptr_width-1:0]   wr_ptr;
    logic [ptr_width-1:0]   rd_ptr;
    logic [count_width-1:0] count;
    logic                   pop;

    logic        busy;
    logic [2:0]  pix_cnt;
    logic [31:0] shifter;
    logic [3:0]  sh_palette;
    logic [1:0]  sh_prio;
    logic [9:0]  sh_x;
    logic        sh_flip;
    logic [3:0]  nibble;
    logic [10:0] x_pos;

    // next row loads on the last pixel of the current one
    assign pop           = (count != '0) && (!busy || pix_cnt == 3'd7);
    assign credit_return = pop;

    // mirrored rows start from the low nibble
    assign nibble = sh_flip ? shifter[3:0] : shifter[31:28];
    assign x_pos  = {1'b0, sh_x} + {8'b0, pix_cnt};

    assign idle = !busy && (count == '0) && !wr_en;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            busy    <= 1'b0;
            pix_cnt <= '0;
            wr_en   <= 1'b0;
        end else begin
            // pointers wrap on their own, depth is a power of two
            if (row_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + count_width'(row_valid) - count_width'(pop);

            if (pop) begin
                busy    <= 1'b1;
                pix_cnt <= '0;
            end else if (busy) begin
                busy    <= (pix_cnt != 3'd7);
                pix_cnt <= pix_cnt + 1'b1;
            end

            wr_en <= busy && (nibble != 4'd0) && (x_pos < 11'(line_width));
        end
    end

    always_ff @(posedge clk) begin
        if (row_valid) begin
            queue[wr_ptr] <= row;
        end
        if (pop) begin
            shifter    <= queue[rd_ptr].pixels;
            sh_palette <= queue[rd_ptr].palette;
            sh_prio    <= queue[rd_ptr].prio;
            sh_x       <= queue[rd_ptr].x_start;
            sh_flip    <= queue[rd_ptr].flip_x;
        end else if (busy) begin
            shifter <= sh_flip ? {4'b0, shifter[31:4]} : {shifter[27:0], 4'b0};
        end
        wr_x     <= x_pos[line_addr_width-1:0];
        wr_pixel <= '{prio: sh_prio, palette: sh_palette, color: nibble};
    end

    // credits in the fetcher must keep the queue from overflowing
    queue_full_a: assert property (@(posedge clk) disable iff (!arst_n)
        row_valid |-> count < count_width'(row_queue_depth));

endmodule

// File: source/sprite_hit_reader.sv
/*
 * sprite hit reader
 * walks the per-line hit list, looks up each sprite's attributes
 * and hands the joined job to the row fetcher
 */
`timescale 1ns/10ps

module sprite_hit_reader import sprite_pkg::*; (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      start,
    output logic [hit_addr_width-1:0] hit_addr,
    input  hit_entry_t                hit_data,
    output logic [7:0]                attr_addr,
    input  sprite_attr_t              attr_data,
    output logic                      job_valid,
    output sprite_job_t               job,
    input  logic                      job_ready,
    output logic                      list_end
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_LIST,
        S_ATTR,
        S_JOIN,
        S_JOB
    } state_t;

    state_t                  state;
    logic [hit_addr_width:0] idx;
    logic [3:0]              line_offset_r;
    logic                    wide_r;

    // one extra index bit so a full list also terminates
    assign hit_addr = idx[hit_addr_width-1:0];

    // attribute table addressed straight from the list word
    assign attr_addr = hit_data.sprite_id;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= S_IDLE;
            idx       <= '0;
            job_valid <= 1'b0;
            list_end  <= 1'b0;
        end else if (start) begin
            state     <= S_LIST;
            idx       <= '0;
            job_valid <= 1'b0;
            list_end  <= 1'b0;
        end else begin
            case (state)
                // data arrives the cycle after the address
                S_LIST: state <= S_ATTR;
                S_ATTR: begin
                    if (hit_data.last || idx == (hit_addr_width + 1)'(hit_list_depth)) begin
                        list_end <= 1'b1;
                        state    <= S_IDLE;
                    end else begin
                        state <= S_JOIN;
                    end
                end
                S_JOIN: begin
                    job_valid <= 1'b1;
                    idx       <= idx + 1'b1;
                    state     <= S_JOB;
                end
                S_JOB: begin
                    // next entry was addressed while the job waited
                    if (job_ready) begin
                        job_valid <= 1'b0;
                        state     <= S_ATTR;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_ATTR) begin
            line_offset_r <= hit_data.line_offset;
            wide_r        <= hit_data.wide;
        end
        if (state == S_JOIN) begin
            job <= '{attr: attr_data, line_offset: line_offset_r, wide: wide_r};
        end
    end

    // the fetcher may sample the job on any cycle it raises ready
    job_hold_a: assert property (@(posedge clk) disable iff (!arst_n || start)
        job_valid && !job_ready |=> job_valid && $stable(job));

endmodule

// File: source/sprite_line_buffer.sv
/*
 * sprite line buffer
 * one scanline of rendered sprite pixels with a written flag
 * per position, cleared at line start and read back by x
 */
`timescale 1ns/10ps

module sprite_line_buffer import sprite_pkg::*; (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       clear,
    input  logic                       wr_en,
    input  logic [line_addr_width-1:0] wr_x,
    input  pixel_t                     wr_pixel,
    input  logic [line_addr_width-1:0] rd_x,
    output pixel_t                     rd_pixel,
    output logic                       rd_valid
);

    pixel_t                  mem [line_width];
    logic [line_width-1:0]   written;

    // clearing only the flags lets a whole line reset in one cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            written  <= '0;
            rd_valid <= 1'b0;
        end else begin
            if (clear) begin
                written <= '0;
            end else if (wr_en) begin
                written[wr_x] <= 1'b1;
            end
            rd_valid <= written[rd_x];
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_x] <= wr_pixel;
        end
        rd_pixel <= mem[rd_x];
    end

endmodule

// File: source/sprite_pkg.sv
/*
 * sprite renderer shared definitions
 * sizes, latencies and the packed words passed between the
 * hit reader, row fetcher, blitter and line buffer
 */
package sprite_pkg;

    localparam int line_width        = 512;
    localparam int vram_read_latency = 3;
    localparam int row_offset        = 128;
    localparam int hit_list_depth    = 256;
    localparam int row_queue_depth   = 2;

    localparam int vram_addr_width = 16;
    localparam int line_addr_width = $clog2(line_width);
    localparam int hit_addr_width  = $clog2(hit_list_depth);

    typedef struct packed {
        logic [7:0] sprite_id;
        logic [3:0] line_offset;
        logic       wide;
        logic       last;
    } hit_entry_t;

    typedef struct packed {
        logic [9:0] character;
        logic [3:0] palette;
        logic [1:0] prio;
        logic [9:0] target_x;
        logic       flip_x;
    } sprite_attr_t;

    typedef struct packed {
        sprite_attr_t attr;
        logic [3:0]   line_offset;
        logic         wide;
    } sprite_job_t;

    typedef struct packed {
        logic [31:0] pixels;
        logic [3:0]  palette;
        logic [1:0]  prio;
        logic [9:0]  x_start;
        logic        flip_x;
        logic        last_row;
    } pattern_row_t;

    typedef struct packed {
        logic [1:0] prio;
        logic [3:0] palette;
        logic [3:0] color;
    } pixel_t;

endpackage

// File: source/sprite_render_top.sv
/*
 * sprite line renderer top level
 * hit reader, row fetcher, blitter and line buffer in series,
 * with the end-of-line done flag
 */
`timescale 1ns/10ps

module sprite_render_top import sprite_pkg::*; (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       start,
    output logic [hit_addr_width-1:0]  hit_addr,
    input  hit_entry_t                 hit_data,
    output logic [7:0]                 attr_addr,
    input  sprite_attr_t               attr_data,
    input  logic [vram_addr_width-1:0] vram_base,
    output logic [vram_addr_width-1:0] vram_addr,
    output logic                       vram_rd,
    input  logic [31:0]                vram_data,
    output logic                       done,
    input  logic [line_addr_width-1:0] rd_x,
    output pixel_t                     rd_pixel,
    output logic                       rd_valid
);

    logic                       job_valid;
    logic                       job_ready;
    sprite_job_t                job;
    logic                       list_end;
    logic                       row_valid;
    pattern_row_t               row;
    logic                       credit_return;
    logic                       fetch_idle;
    logic                       blit_idle;
    logic                       wr_en;
    logic [line_addr_width-1:0] wr_x;
    pixel_t                     wr_pixel;

    sprite_hit_reader u_hit_reader (
        .clk       (clk),
        .arst_n    (arst_n),
        .start     (start),
        .hit_addr  (hit_addr),
        .hit_data  (hit_data),
        .attr_addr (attr_addr),
        .attr_data (attr_data),
        .job_valid (job_valid),
        .job       (job),
        .job_ready (job_ready),
        .list_end  (list_end)
    );

    sprite_row_fetch u_row_fetch (
        .clk           (clk),
        .arst_n        (arst_n),
        .vram_base     (vram_base),
        .job_valid     (job_valid),
        .job           (job),
        .job_ready     (job_ready),
        .vram_addr     (vram_addr),
        .vram_rd       (vram_rd),
        .vram_data     (vram_data),
        .row_valid     (row_valid),
        .row           (row),
        .credit_return (credit_return),
        .idle          (fetch_idle)
    );

    sprite_blitter u_blitter (
        .clk           (clk),
        .arst_n        (arst_n),
        .row_valid     (row_valid),
        .row           (row),
        .credit_return (credit_return),
        .wr_en         (wr_en),
        .wr_x          (wr_x),
        .wr_pixel      (wr_pixel),
        .idle          (blit_idle)
    );

    sprite_line_buffer u_line_buffer (
        .clk      (clk),
        .arst_n   (arst_n),
        .clear    (start),
        .wr_en    (wr_en),
        .wr_x     (wr_x),
        .wr_pixel (wr_pixel),
        .rd_x     (rd_x),
        .rd_pixel (rd_pixel),
        .rd_valid (rd_valid)
    );

    // fetch idle also means every credit is back
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            done <= 1'b0;
        end else if (start) begin
            done <= 1'b0;
        end else if (list_end && fetch_idle && blit_idle) begin
            done <= 1'b1;
        end
    end

endmodule

// File: source/sprite_row_fetch.sv
/*
 * sprite pattern row fetcher
 * turns a job into one or two video memory reads and sends each
 * returned row to the blitter, throttled by row queue credits
 */
`timescale 1ns/10ps

module sprite_row_fetch import sprite_pkg::*; (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic [vram_addr_width-1:0] vram_base,
    input  logic                       job_valid,
    input  sprite_job_t                job,
    output logic                       job_ready,
    output logic [vram_addr_width-1:0] vram_addr,
    output logic                       vram_rd,
    input  logic [31:0]                vram_data,
    output logic                       row_valid,
    output pattern_row_t               row,
    input  logic                       credit_return,
    output logic                       idle
);

    localparam int lat_width    = $clog2(vram_read_latency);
    localparam int credit_width = $clog2(row_queue_depth + 1);

    typedef enum logic [1:0] {
        S_IDLE,
        S_ISSUE,
        S_WAIT
    } state_t;

    state_t                   state;
    sprite_job_t              job_r;
    logic                     second;
    logic [lat_width-1:0]     lat_cnt;
    logic [credit_width-1:0]  credits;
    logic [credit_width-1:0]  avail;
    logic                     can_issue;
    logic                     data_here;
    logic [vram_addr_width-1:0] first_addr;
    logic [9:0]               x_start;

    // pattern rows are 8 words per character, lower half 128 words on
    assign first_addr = vram_base
                      + vram_addr_width'({job.attr.character, 3'b000})
                      + vram_addr_width'(job.line_offset[2:0])
                      + (job.line_offset[3] ? vram_addr_width'(row_offset) : '0);

    // a row leaving this cycle already owns a credit
    assign avail     = credits - credit_width'(row_valid);
    assign can_issue = (avail != '0);
    assign data_here = (state == S_WAIT) && (lat_cnt == lat_width'(vram_read_latency - 1));

    assign job_ready = (state == S_IDLE);
    assign vram_rd   = (state == S_ISSUE) && can_issue;

    // flipped wide sprite draws its first row on the right half
    assign x_start = job_r.attr.target_x
                   + (((second ^ (job_r.attr.flip_x & job_r.wide)) != 1'b0) ? 10'd8 : 10'd0);

    // includes full credits, so nothing sits in the blitter queue
    assign idle = (state == S_IDLE) && !row_valid
                && (credits == credit_width'(row_queue_depth));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= S_IDLE;
            second    <= 1'b0;
            lat_cnt   <= '0;
            row_valid <= 1'b0;
            credits   <= credit_width'(row_queue_depth);
        end else begin
            row_valid <= data_here;
            credits   <= credits - credit_width'(row_valid) + credit_width'(credit_return);
            case (state)
                S_IDLE: begin
                    if (job_valid) begin
                        second <= 1'b0;
                        state  <= S_ISSUE;
                    end
                end
                S_ISSUE: begin
                    if (can_issue) begin
                        lat_cnt <= '0;
                        state   <= S_WAIT;
                    end
                end
                S_WAIT: begin
                    lat_cnt <= lat_cnt + 1'b1;
                    if (data_here) begin
                        if (job_r.wide && !second) begin
                            second <= 1'b1;
                            state  <= S_ISSUE;
                        end else begin
                            state <= S_IDLE;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (job_ready && job_valid) begin
            job_r     <= job;
            vram_addr <= first_addr;
        end else if (data_here) begin
            // second half sits one character further on
            vram_addr <= vram_addr + vram_addr_width'(8);
        end
        if (data_here) begin
            row.pixels   <= vram_data;
            row.palette  <= job_r.attr.palette;
            row.prio     <= job_r.attr.prio;
            row.x_start  <= x_start;
            row.flip_x   <= job_r.attr.flip_x;
            row.last_row <= 1'b0;
        end
    end

    credit_max_a: assert property (@(posedge clk) disable iff (!arst_n)
        credits <= credit_width'(row_queue_depth));

    credit_send_a: assert property (@(posedge clk) disable iff (!arst_n)
        row_valid |-> credits != '0);

endmodule

// File: sources.f
source/sprite_pkg.sv
source/sprite_hit_reader.sv
source/sprite_row_fetch.sv
source/sprite_blitter.sv
source/sprite_line_buffer.sv
source/sprite_render_top.sv
tests/sprite_render_tb.sv

// File: tests/sprite_render_tb.sv
/*
 * sprite line renderer testbench
 * models the hit list, attribute table and video memory, paints a
 * reference line for each scanline and reads the line buffer back
 */
`timescale 1ns/10ps

module sprite_render_tb import sprite_pkg::*; ();

    logic                       clk;
    logic                       arst_n;
    logic                       start;
    logic [hit_addr_width-1:0]  hit_addr;
    hit_entry_t                 hit_data = '0;
    logic [7:0]                 attr_addr;
    sprite_attr_t               attr_data = '0;
    logic [vram_addr_width-1:0] vram_base;
    logic [vram_addr_width-1:0] vram_addr;
    logic                       vram_rd;
    logic [31:0]                vram_data = '0;
    logic                       done;
    logic [line_addr_width-1:0] rd_x;
    pixel_t                     rd_pixel;
    logic                       rd_valid;

    hit_entry_t                hit_mem   [hit_list_depth];
    sprite_attr_t              attr_mem  [256];
    logic [31:0]               vram      [2**vram_addr_width];
    logic [hit_addr_width-1:0] hit_addr_q;
    logic [7:0]                attr_addr_q;
    logic [31:0]               vram_pipe [vram_read_latency];
    pixel_t                    ref_pix   [line_width];
    logic                      ref_valid [line_width];
    logic [31:0]               rng;

    sprite_render_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // addresses latched on the rising edge and answers driven on the falling edge
    always @(posedge clk) begin
        hit_addr_q   <= hit_addr;
        attr_addr_q  <= attr_addr;
        vram_pipe[0] <= vram_rd ? vram[vram_addr] : 'x;
        for (int i = 1; i < vram_read_latency; i++) begin
            vram_pipe[i] <= vram_pipe[i-1];
        end
    end

    always @(negedge clk) begin
        hit_data  <= hit_mem[hit_addr_q];
        attr_data <= attr_mem[attr_addr_q];
        vram_data <= vram_pipe[vram_read_latency-1];
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] v;
        v = s ^ (s << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    // model line painted in hit list order so later opaque pixels win
    function automatic void paint_line();
        hit_entry_t   e;
        sprite_attr_t a;
        logic [15:0]  addr;
        logic [31:0]  word;
        logic [3:0]   nib;
        int           xs;
        int           x;
        for (int i = 0; i < line_width; i++) begin
            ref_valid[i] = 1'b0;
        end
        for (int n = 0; n < hit_list_depth; n++) begin
            e = hit_mem[n];
            if (e.last) break;
            a = attr_mem[e.sprite_id];
            for (int r = 0; r < (e.wide ? 2 : 1); r++) begin
                addr = 16'(int'(vram_base) + int'(a.character) * 8 + int'(e.line_offset[2:0])
                           + (e.line_offset[3] ? row_offset : 0) + r * 8);
                word = vram[addr];
                // flipped wide sprite puts its first row on the right half
                xs = int'(a.target_x) + (((r == 1) != (a.flip_x && e.wide)) ? 8 : 0);
                for (int i = 0; i < 8; i++) begin
                    nib = a.flip_x ? word[4*i +: 4] : word[28-4*i +: 4];
                    x   = xs + i;
                    if (nib != 4'd0 && x < line_width) begin
                        ref_valid[x] = 1'b1;
                        ref_pix[x]   = '{prio: a.prio, palette: a.palette, color: nib};
                    end
                end
            end
        end
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_pixel(input int x, input pixel_t got, input pixel_t exp);
        if (got !== exp) begin
            stop_run($sformatf("** Error: rd_pixel at x=%0d got %h expected %h", x, got, exp));
        end
    endtask

    task automatic check_valid(input int x, input logic got, input logic exp);
        if (got !== exp) begin
            stop_run($sformatf("** Error: rd_valid at x=%0d got %h expected %h", x, got, exp));
        end
    endtask

    task automatic fill_memories();
        logic [31:0] w;
        for (int a = 0; a < 2**vram_addr_width; a++) begin
            rng = xorshift(rng);
            w   = rng;
            rng = xorshift(rng);
            // two draws anded leave about a third of the nibbles transparent
            vram[a] = w & rng;
        end
        for (int i = 0; i < 256; i++) begin
            attr_mem[i] = '0;
            hit_mem[i]  = '0;
        end
    endtask

    task automatic set_sprite(input int n, input logic [7:0] id, input logic [3:0] lo,
                              input logic wide, input logic [9:0] chr, input logic [3:0] pal,
                              input logic [1:0] pri, input logic [9:0] x, input logic flip);
        hit_mem[n]   = '{sprite_id: id, line_offset: lo, wide: wide, last: 1'b0};
        attr_mem[id] = '{character: chr, palette: pal, prio: pri, target_x: x, flip_x: flip};
    endtask

    task automatic end_list(input int n);
        hit_mem[n] = '{sprite_id: 8'd0, line_offset: 4'd0, wide: 1'b0, last: 1'b1};
    endtask

    task automatic wait_done(input int limit);
        int cycles;
        cycles = 0;
        while (!done) begin
            @(negedge clk);
            cycles++;
            if (cycles > limit) begin
                stop_run("timeout: done did not rise within the cycle limit");
            end
        end
    endtask

    // rd_x set on one falling edge and the answer checked on the next
    task automatic check_line();
        for (int x = 0; x < line_width; x++) begin
            @(negedge clk);
            rd_x = line_addr_width'(x);
            @(negedge clk);
            check_valid(x, rd_valid, ref_valid[x]);
            if (ref_valid[x]) begin
                check_pixel(x, rd_pixel, ref_pix[x]);
            end
        end
    endtask

    task automatic run_line();
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        if (done !== 1'b0) begin
            stop_run("done still high after a new start");
        end
        wait_done(20000);
        paint_line();
        check_line();
    endtask

    initial begin
        int tx;
        arst_n    = 1'b0;
        start     = 1'b0;
        vram_base = 16'h0400;
        rd_x      = '0;
        rng       = 32'h9c74_e413;
        fill_memories();
        repeat (16) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        if (done !== 1'b0 || rd_valid !== 1'b0 || vram_rd !== 1'b0) begin
            stop_run("outputs not low after reset");
        end

        // single narrow sprite with transparent gaps
        set_sprite(0, 8'd5, 4'd2, 1'b0, 10'd3, 4'd7, 2'd2, 10'd20, 1'b0);
        end_list(1);
        vram[16'h0400 + 16'd26] = 32'h1203_0450;
        run_line();

        // narrow and wide sprites with flip off and on and lower half offsets
        set_sprite(0, 8'd10, 4'd1, 1'b0, 10'd40, 4'd1, 2'd0, 10'd40, 1'b0);
        set_sprite(1, 8'd11, 4'd5, 1'b0, 10'd41, 4'd2, 2'd1, 10'd60, 1'b1);
        set_sprite(2, 8'd12, 4'd11, 1'b1, 10'd42, 4'd3, 2'd2, 10'd80, 1'b0);
        set_sprite(3, 8'd13, 4'd14, 1'b1, 10'd44, 4'd4, 2'd3, 10'd120, 1'b1);
        end_list(4);
        run_line();

        // overlapping sprites where the second has every other pixel clear
        set_sprite(0, 8'd20, 4'd0, 1'b1, 10'd50, 4'd5, 2'd1, 10'd200, 1'b0);
        set_sprite(1, 8'd21, 4'd0, 1'b0, 10'd60, 4'd6, 2'd2, 10'd204, 1'b0);
        end_list(2);
        vram[16'h0400 + 16'd400] = 32'h1111_1111;
        vram[16'h0400 + 16'd408] = 32'h2222_2222;
        vram[16'h0400 + 16'd480] = 32'h3030_3030;
        run_line();

        // stress line with every eighth sprite near the right edge
        vram_base = 16'h0800;
        for (int n = 0; n < 40; n++) begin
            rng = xorshift(rng);
            tx  = (n % 8 == 0) ? 500 + int'(rng[25:22]) : int'(rng[31:22]) % 560;
            set_sprite(n, 8'(n * 3 + 1), rng[21:18], rng[17], rng[9:0], rng[13:10],
                       rng[15:14], 10'(tx), rng[16]);
        end
        end_list(40);
        run_line();

        // next scanline must hold only its own sprites
        vram_base = 16'h3000;
        set_sprite(0, 8'd200, 4'd9, 1'b1, 10'd700, 4'd9, 2'd1, 10'd300, 1'b1);
        set_sprite(1, 8'd201, 4'd3, 1'b0, 10'd12, 4'd10, 2'd0, 10'd8, 1'b0);
        end_list(2);
        run_line();

        // empty list
        end_list(0);
        run_line();

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule
